//--- rtl/tiny32_pkg.sv
package tiny32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // one instruction walks through all four stages before the next fetch
    typedef enum logic [1:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory
    } stage_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu
    } alu_op_e;

    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    // custom-0 space holds the core's own control instructions
    localparam logic [6:0] opc_system = 7'b0001011;
    localparam logic [2:0] f3_hlt     = 3'd2;

    // class flags are one-hot, imm is already sign extended for its format
    typedef struct packed {
        logic       alu;
        logic       load;
        logic       store;
        logic       branch;
        logic       jal;
        logic       jalr;
        logic       lui;
        logic       hlt;
        logic       alu_imm;
        alu_op_e    alu_op;
        logic [2:0] funct3;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
    } decoded_t;

endpackage

//--- rtl/stage_sequencer.sv
`timescale 1ns/1ns

module stage_sequencer (
    input  logic               clk,
    input  logic               nreset,
    input  logic               ready,
    input  logic               mem_op,
    input  logic               halt_req,
    input  logic               error_req,
    output tiny32_pkg::stage_e stage,
    output logic               run,
    output logic               hlt,
    output logic               error
);
    import tiny32_pkg::*;

    logic bus_wait;

    // a fetch always uses the bus, the memory stage only for lw and sw
    assign bus_wait = !ready && (stage == st_fetch || (stage == st_memory && mem_op));

    always_ff @(posedge clk) begin
        if (!nreset) begin
            stage <= st_fetch;
            run   <= 1'b0;
            hlt   <= 1'b0;
            error <= 1'b0;
        end else if (!run) begin
            // start-up takes one idle cycle, a stopped core never restarts
            run <= !(hlt || error);
        end else if (stage == st_execute && (halt_req || error_req)) begin
            // stopping before the memory stage keeps a faulty store off the bus
            error <= error_req;
            hlt   <= !error_req;
            run   <= 1'b0;
        end else if (!bus_wait) begin
            stage <= stage_e'(stage + 2'd1);
        end
    end

endmodule

//--- rtl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic                 clk,
    input  logic                 nreset,
    input  tiny32_pkg::stage_e   stage,
    input  logic                 run,
    input  logic                 ready,
    input  tiny32_pkg::word_t    data_in,
    output tiny32_pkg::decoded_t decoded,
    output logic                 illegal
);
    import tiny32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    decoded_t   dec_next;
    logic       bad;

    function automatic alu_op_e alu_op_f(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: alu_op_f = alt ? alu_sub : alu_add;
            3'd1: alu_op_f = alu_sll;
            3'd2: alu_op_f = alu_slt;
            3'd3: alu_op_f = alu_sltu;
            3'd4: alu_op_f = alu_xor;
            3'd5: alu_op_f = alt ? alu_sra : alu_srl;
            3'd6: alu_op_f = alu_or;
            default: alu_op_f = alu_and;
        endcase
    endfunction

    assign opcode = data_in[6:0];
    assign funct3 = data_in[14:12];
    assign funct7 = data_in[31:25];

    assign imm_i = {{20{data_in[31]}}, data_in[31:20]};
    assign imm_s = {{20{data_in[31]}}, data_in[31:25], data_in[11:7]};
    assign imm_b = {{19{data_in[31]}}, data_in[31], data_in[7], data_in[30:25],
                    data_in[11:8], 1'b0};
    assign imm_j = {{11{data_in[31]}}, data_in[31], data_in[19:12], data_in[20],
                    data_in[30:21], 1'b0};
    assign imm_u = {data_in[31:12], 12'b0};

    always_comb begin
        dec_next        = '0;
        bad             = 1'b0;
        dec_next.alu_op = alu_add;
        dec_next.funct3 = funct3;
        dec_next.rd     = data_in[11:7];
        dec_next.rs1    = data_in[19:15];
        dec_next.rs2    = data_in[24:20];
        case (opcode)
            opc_load: begin
                dec_next.load = 1'b1;
                dec_next.imm  = imm_i;
                bad           = funct3 != 3'd2;
            end
            opc_store: begin
                dec_next.store = 1'b1;
                dec_next.imm   = imm_s;
                bad            = funct3 != 3'd2;
            end
            opc_op_imm: begin
                dec_next.alu     = 1'b1;
                dec_next.alu_imm = 1'b1;
                dec_next.imm     = imm_i;
                // for addi funct7 is immediate bits, so only srai reads bit 30
                dec_next.alu_op  = alu_op_f(funct3, funct3 == 3'd5 && funct7[5]);
                bad = (funct3 == 3'd1 && funct7 != 7'h00) ||
                      (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20);
            end
            opc_op: begin
                dec_next.alu    = 1'b1;
                dec_next.alu_op = alu_op_f(funct3, funct7[5]);
                bad = !(funct7 == 7'h00 ||
                        (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)));
            end
            opc_branch: begin
                dec_next.branch = 1'b1;
                dec_next.imm    = imm_b;
                dec_next.alu_op = alu_sub;
                bad             = funct3[2:1] == 2'b01;
            end
            opc_jal: begin
                dec_next.jal = 1'b1;
                dec_next.imm = imm_j;
            end
            opc_jalr: begin
                dec_next.jalr = 1'b1;
                dec_next.imm  = imm_i;
                bad           = funct3 != 3'd0;
            end
            opc_lui: begin
                dec_next.lui = 1'b1;
                dec_next.imm = imm_u;
            end
            opc_system: begin
                dec_next.hlt = funct3 == f3_hlt;
                bad          = funct3 != f3_hlt;
            end
            default: bad = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            decoded <= '0;
            illegal <= 1'b0;
        end else if (run && stage == st_fetch && ready) begin
            decoded <= dec_next;
            illegal <= bad;
        end
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                  clk,
    input  tiny32_pkg::stage_e    stage,
    input  tiny32_pkg::reg_addr_t rs1,
    input  tiny32_pkg::reg_addr_t rs2,
    input  tiny32_pkg::reg_addr_t rd,
    input  logic                  wb_en,
    input  tiny32_pkg::word_t     wb_data,
    output tiny32_pkg::word_t     rs1_data,
    output tiny32_pkg::word_t     rs2_data
);
    import tiny32_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        // rd and wb_data still belong to the previous instruction during fetch,
        // a stalled fetch writes the same value again
        if (stage == st_fetch && wb_en) begin
            regs[rd] <= wb_data;
        end
        if (stage == st_decode) begin
            rs1_data <= (rs1 == '0) ? '0 : regs[rs1];
            rs2_data <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic                 clk,
    input  tiny32_pkg::stage_e   stage,
    input  tiny32_pkg::decoded_t decoded,
    input  tiny32_pkg::word_t    rs1_data,
    input  tiny32_pkg::word_t    rs2_data,
    output tiny32_pkg::word_t    alu_result,
    output logic                 take_branch
);
    import tiny32_pkg::*;

    word_t op2;
    word_t diff;
    logic  carry;
    logic  zero;
    logic  signed_lt;
    logic  cond;

    assign op2 = decoded.alu_imm ? decoded.imm : rs2_data;

    // carry is the borrow of rs1 - op2, so it means unsigned less-than
    assign {carry, diff} = {1'b0, rs1_data} - {1'b0, op2};
    assign zero          = diff == '0;
    assign signed_lt     = (rs1_data[31] != op2[31]) ? rs1_data[31] : diff[31];

    always_comb begin
        case (decoded.funct3)
            3'b000:  cond = zero;
            3'b001:  cond = !zero;
            3'b100:  cond = signed_lt;
            3'b101:  cond = !signed_lt;
            3'b110:  cond = carry;
            3'b111:  cond = !carry;
            default: cond = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (stage == st_execute) begin
            take_branch <= decoded.branch && cond;
            case (decoded.alu_op)
                alu_add:  alu_result <= rs1_data + op2;
                alu_sub:  alu_result <= diff;
                alu_sll:  alu_result <= rs1_data << op2[4:0];
                alu_srl:  alu_result <= rs1_data >> op2[4:0];
                alu_sra:  alu_result <= $signed(rs1_data) >>> op2[4:0];
                alu_and:  alu_result <= rs1_data & op2;
                alu_or:   alu_result <= rs1_data | op2;
                alu_xor:  alu_result <= rs1_data ^ op2;
                alu_slt:  alu_result <= {31'b0, signed_lt};
                alu_sltu: alu_result <= {31'b0, carry};
                default:  alu_result <= '0;
            endcase
        end
    end

endmodule

//--- rtl/pc_unit.sv
`timescale 1ns/1ns

module pc_unit #(
    parameter tiny32_pkg::word_t reset_pc = 32'h0
) (
    input  logic                 clk,
    input  logic                 nreset,
    input  tiny32_pkg::stage_e   stage,
    input  logic                 ready,
    input  tiny32_pkg::decoded_t decoded,
    input  logic                 take_branch,
    input  tiny32_pkg::word_t    rs1_data,
    output tiny32_pkg::word_t    pc
);
    import tiny32_pkg::*;

    word_t pc_plus4;
    word_t rel_target;
    word_t jalr_target;
    logic  mem_done;

    assign pc_plus4    = pc + 32'd4;
    // branches and jal share the pc-relative adder
    assign rel_target  = pc + decoded.imm;
    assign jalr_target = rs1_data + decoded.imm;

    // only lw and sw wait for ready in the memory stage
    assign mem_done = stage == st_memory && (ready || !(decoded.load || decoded.store));

    always_ff @(posedge clk) begin
        if (!nreset) begin
            pc <= reset_pc;
        end else if (mem_done) begin
            if (decoded.jalr) begin
                pc <= {jalr_target[31:1], 1'b0};
            end else if (decoded.jal || (decoded.branch && take_branch)) begin
                pc <= rel_target;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

endmodule

//--- rtl/mem_writeback.sv
`timescale 1ns/1ns

module mem_writeback (
    input  logic                 clk,
    input  tiny32_pkg::stage_e   stage,
    input  logic                 run,
    input  logic                 ready,
    input  tiny32_pkg::decoded_t decoded,
    input  tiny32_pkg::word_t    rs1_data,
    input  tiny32_pkg::word_t    rs2_data,
    input  tiny32_pkg::word_t    alu_result,
    input  tiny32_pkg::word_t    pc,
    input  tiny32_pkg::word_t    data_in,
    output tiny32_pkg::word_t    mem_address,
    output tiny32_pkg::word_t    data_out,
    output logic                 nrd,
    output logic                 nwr,
    output logic                 wb_en,
    output tiny32_pkg::word_t    wb_data,
    output logic                 misaligned
);
    import tiny32_pkg::*;

    word_t data_addr;
    word_t link;
    logic  mem_op;

    assign data_addr  = rs1_data + decoded.imm;
    assign link       = pc + 32'd4;
    assign mem_op     = decoded.load || decoded.store;
    // only valid from execute on, once rs1_data has been read
    assign misaligned = mem_op && data_addr[1:0] != 2'b00;

    // pc and rs1_data are both held steady while a strobe waits for ready
    assign mem_address = (stage == st_memory) ? data_addr : pc;
    assign data_out    = rs2_data;
    assign nrd = !(run && (stage == st_fetch || (stage == st_memory && decoded.load)));
    assign nwr = !(run && stage == st_memory && decoded.store);

    assign wb_en = (decoded.alu || decoded.load || decoded.jal || decoded.jalr ||
                    decoded.lui) && decoded.rd != '0;

    always_ff @(posedge clk) begin
        if (stage == st_memory && (ready || !mem_op)) begin
            if (decoded.load) begin
                wb_data <= data_in;
            end else if (decoded.lui) begin
                wb_data <= decoded.imm;
            end else if (decoded.jal || decoded.jalr) begin
                wb_data <= link;
            end else begin
                wb_data <= alu_result;
            end
        end
    end

endmodule

//--- rtl/tiny32_core.sv
`timescale 1ns/1ns

module tiny32_core #(
    parameter tiny32_pkg::word_t reset_pc = 32'h0
) (
    input  logic              clk,
    input  logic              nreset,
    input  logic              ready,
    input  tiny32_pkg::word_t data_in,
    output tiny32_pkg::word_t address,
    output tiny32_pkg::word_t data_out,
    output logic              nrd,
    output logic              nwr,
    output logic              hlt,
    output logic              error
);
    import tiny32_pkg::*;

    stage_e   stage;
    logic     run;
    decoded_t decoded;
    logic     illegal;
    logic     misaligned;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    logic     take_branch;
    word_t    pc;
    logic     wb_en;
    word_t    wb_data;

    stage_sequencer i_stage_sequencer (
        .clk       (clk),
        .nreset    (nreset),
        .ready     (ready),
        .mem_op    (decoded.load | decoded.store),
        .halt_req  (decoded.hlt),
        .error_req (illegal | misaligned),
        .stage     (stage),
        .run       (run),
        .hlt       (hlt),
        .error     (error)
    );

    instr_decoder i_instr_decoder (
        .clk     (clk),
        .nreset  (nreset),
        .stage   (stage),
        .run     (run),
        .ready   (ready),
        .data_in (data_in),
        .decoded (decoded),
        .illegal (illegal)
    );

    register_file i_register_file (
        .clk      (clk),
        .stage    (stage),
        .rs1      (decoded.rs1),
        .rs2      (decoded.rs2),
        .rd       (decoded.rd),
        .wb_en    (wb_en),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu i_alu (
        .clk         (clk),
        .stage       (stage),
        .decoded     (decoded),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .take_branch (take_branch)
    );

    pc_unit #(
        .reset_pc (reset_pc)
    ) i_pc_unit (
        .clk         (clk),
        .nreset      (nreset),
        .stage       (stage),
        .ready       (ready),
        .decoded     (decoded),
        .take_branch (take_branch),
        .rs1_data    (rs1_data),
        .pc          (pc)
    );

    mem_writeback i_mem_writeback (
        .clk         (clk),
        .stage       (stage),
        .run         (run),
        .ready       (ready),
        .decoded     (decoded),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .pc          (pc),
        .data_in     (data_in),
        .mem_address (address),
        .data_out    (data_out),
        .nrd         (nrd),
        .nwr         (nwr),
        .wb_en       (wb_en),
        .wb_data     (wb_data),
        .misaligned  (misaligned)
    );

endmodule

//--- dv/tiny32_properties.sv
`timescale 1ns/1ns

module tiny32_properties (
    input logic              clk,
    input logic              nreset,
    input logic              ready,
    input tiny32_pkg::word_t address,
    input logic              nrd,
    input logic              nwr,
    input logic              hlt,
    input logic              error
);

    int failures = 0;

    // a read and a write never share the bus
    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (!nreset) !(!nrd && !nwr)
    ) else begin
        failures++;
        $error("nrd and nwr low together");
    end

    // the address holds while a strobe waits for ready
    a_address_stable: assert property (
        @(posedge clk) disable iff (!nreset)
        ((!nrd || !nwr) && !ready) |=> $stable(address)
    ) else begin
        failures++;
        $error("address changed during a stalled transfer");
    end

    a_quiet_after_stop: assert property (
        @(posedge clk) disable iff (!nreset)
        (hlt || error) |-> (nrd && nwr)
    ) else begin
        failures++;
        $error("bus strobe after hlt or error");
    end

    a_stop_sticky: assert property (
        @(posedge clk) disable iff (!nreset)
        (hlt || error) |=> (hlt || error)
    ) else begin
        failures++;
        $error("hlt or error dropped without reset");
    end

endmodule

//--- dv/tb_tiny32.sv
`timescale 1ns/1ns

module tb_tiny32;
    import tiny32_pkg::*;

    localparam int mem_words = 1024;
    localparam int rand_len  = 40;

    logic  clk;
    logic  nreset;
    logic  ready;
    word_t data_in;
    word_t address;
    word_t data_out;
    logic  nrd;
    logic  nwr;
    logic  hlt;
    logic  error;

    int    seed;
    int    errors;
    int    checks;
    int    prog_len;
    word_t mem [0:mem_words-1];

    // instruction-set model state
    word_t m_regs [0:31];
    word_t m_mem [0:mem_words-1];
    word_t m_pc;
    int    stop_exp;
    logic  exp_data;
    logic  exp_write;
    word_t exp_addr;
    word_t exp_wdata;

    tiny32_core #(
        .reset_pc (32'h0)
    ) i_tiny32_core (
        .clk      (clk),
        .nreset   (nreset),
        .ready    (ready),
        .data_in  (data_in),
        .address  (address),
        .data_out (data_out),
        .nrd      (nrd),
        .nwr      (nwr),
        .hlt      (hlt),
        .error    (error)
    );

    bind tiny32_core tiny32_properties i_tiny32_properties (
        .clk     (clk),
        .nreset  (nreset),
        .ready   (ready),
        .address (address),
        .nrd     (nrd),
        .nwr     (nwr),
        .hlt     (hlt),
        .error   (error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
        enc_s = {imm[11:5], rs2, rs1, 3'd2, imm[4:0], opc_store};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: alu_model = alt ? a - b : a + b;
            3'd1: alu_model = a << b[4:0];
            3'd2: alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: alu_model = (a < b) ? 32'd1 : 32'd0;
            3'd4: alu_model = a ^ b;
            3'd5: begin
                if (alt) begin
                    alu_model = word_t'($signed(a) >>> b[4:0]);
                end else begin
                    alu_model = a >> b[4:0];
                end
            end
            3'd6: alu_model = a | b;
            default: alu_model = a & b;
        endcase
    endfunction

    // random legal program: register setup, random body, register dump, hlt
    task automatic build_random_program();
        int p;
        int sel;
        logic [2:0] f3;
        logic [11:0] imm;
        logic [2:0] br_f3 [0:5];
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        p = 0;
        for (int r = 1; r < 32; r++) begin
            mem[p] = enc_i(12'($random(seed)), 5'd0, 3'd0, 5'(r), opc_op_imm);
            p++;
        end
        for (int k = 0; k < rand_len; k++) begin
            sel = {$random(seed)} % 8;
            f3  = 3'($random(seed));
            case (sel)
                0, 1: begin
                    mem[p] = {((f3 == 3'd0 || f3 == 3'd5) && $random(seed) % 2 != 0)
                              ? 7'h20 : 7'h00, 5'($random(seed)), 5'($random(seed)),
                              f3, 5'($random(seed)), opc_op};
                end
                2: begin
                    imm = 12'($random(seed));
                    if (f3 == 3'd1) imm[11:5] = 7'h00;
                    if (f3 == 3'd5) imm[11:5] = imm[10] ? 7'h20 : 7'h00;
                    mem[p] = enc_i(imm, 5'($random(seed)), f3, 5'($random(seed)),
                                   opc_op_imm);
                end
                3: mem[p] = {20'($random(seed)), 5'($random(seed)), opc_lui};
                4: mem[p] = enc_i(12'h400 + 12'(4 * ({$random(seed)} % 256)), 5'd0,
                                  3'd2, 5'($random(seed)), opc_load);
                5: mem[p] = enc_s(12'h400 + 12'(4 * ({$random(seed)} % 256)),
                                  5'($random(seed)), 5'd0);
                6: mem[p] = enc_b(13'(4 * (1 + {$random(seed)} % 3)), 5'($random(seed)),
                                  5'($random(seed)), br_f3[{$random(seed)} % 6]);
                default: begin
                    if ($random(seed) % 2 != 0) begin
                        mem[p] = enc_j(21'(4 * (1 + {$random(seed)} % 2)),
                                       5'($random(seed)));
                    end else begin
                        mem[p] = enc_i(12'(4 * (p + 2)), 5'd0, 3'd0, 5'($random(seed)),
                                       opc_jalr);
                    end
                end
            endcase
            p++;
        end
        for (int r = 0; r < 32; r++) begin
            mem[p] = enc_s(12'h400 + 12'(4 * r), 5'(r), 5'd0);
            p++;
        end
        mem[p] = {17'b0, f3_hlt, 5'b0, opc_system};
        p++;
        prog_len = p;
    endtask

    // executes one fetched word and records the data access it must cause
    task automatic model_exec(input word_t ins);
        word_t rs1v;
        word_t rs2v;
        word_t imm_i;
        word_t next_pc;
        word_t val;
        word_t addr;
        logic  wr;
        logic  cond;
        rs1v    = m_regs[ins[19:15]];
        rs2v    = m_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        next_pc = m_pc + 32'd4;
        wr      = 1'b0;
        val     = '0;
        case (ins[6:0])
            opc_op: begin
                wr  = 1'b1;
                val = alu_model(ins[14:12], ins[30], rs1v, rs2v);
            end
            opc_op_imm: begin
                wr  = 1'b1;
                val = alu_model(ins[14:12], ins[14:12] == 3'd5 && ins[30], rs1v, imm_i);
            end
            opc_load, opc_store: begin
                addr = rs1v + ((ins[6:0] == opc_load) ? imm_i
                               : {{20{ins[31]}}, ins[31:25], ins[11:7]});
                if (addr[1:0] != 2'b00) begin
                    stop_exp = 2;
                end else begin
                    exp_data  = 1'b1;
                    exp_addr  = addr;
                    exp_write = ins[6:0] == opc_store;
                    exp_wdata = rs2v;
                    wr        = !exp_write;
                    val       = m_mem[addr[11:2]];
                    if (exp_write) begin
                        m_mem[addr[11:2]] = rs2v;
                    end
                end
            end
            opc_branch: begin
                case (ins[14:12])
                    3'd0: cond = rs1v == rs2v;
                    3'd1: cond = rs1v != rs2v;
                    3'd4: cond = $signed(rs1v) < $signed(rs2v);
                    3'd5: cond = $signed(rs1v) >= $signed(rs2v);
                    3'd6: cond = rs1v < rs2v;
                    default: cond = rs1v >= rs2v;
                endcase
                if (cond) begin
                    next_pc = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                      ins[11:8], 1'b0};
                end
            end
            opc_jal: begin
                wr      = 1'b1;
                val     = m_pc + 32'd4;
                next_pc = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                  ins[30:21], 1'b0};
            end
            opc_jalr: begin
                wr      = 1'b1;
                val     = m_pc + 32'd4;
                next_pc = (rs1v + imm_i) & ~32'd1;
            end
            opc_lui: begin
                wr  = 1'b1;
                val = {ins[31:12], 12'b0};
            end
            opc_system: stop_exp = (ins[14:12] == f3_hlt) ? 1 : 2;
            default: stop_exp = 2;
        endcase
        if (wr && ins[11:7] != 5'd0 && stop_exp == 0) begin
            m_regs[ins[11:7]] = val;
        end
        m_pc = next_pc;
    endtask

    task automatic run_test(input int kind);
        int    cyc;
        int    limit;
        int    quiet;
        int    wait_left;
        int    last_fetch;
        int    stall_cycles;
        logic  in_xfer;
        logic  xfer_fetch;
        logic  done;
        word_t xfer_addr;
        nreset = 1'b0;
        ready  = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        if (kind == 0) begin
            build_random_program();
        end else begin
            mem[0] = enc_i(12'h402, 5'd0, 3'd0, 5'd1, opc_op_imm);
            mem[1] = enc_s(12'h400, 5'd1, 5'd0);
            // the illegal run uses an unknown opcode, the other a misaligned lw
            mem[2] = (kind == 1) ? 32'h0000007f : enc_i(12'h0, 5'd1, 3'd2, 5'd2, opc_load);
            mem[3] = enc_s(12'h404, 5'd1, 5'd0);
            prog_len = 4;
        end
        m_regs   = '{default: '0};
        m_mem    = mem;
        m_pc     = 32'h0;
        stop_exp = 0;
        exp_data = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        nreset = 1'b1;
        expect_true(nrd && nwr && !hlt && !error, "outputs not idle after reset");
        limit        = prog_len * 4 * 5;
        cyc          = 0;
        quiet        = 0;
        last_fetch   = -1;
        stall_cycles = 0;
        in_xfer      = 1'b0;
        xfer_fetch   = 1'b0;
        done         = 1'b0;
        while (!done) begin
            @(negedge clk);
            cyc++;
            if (ready) begin
                ready   = 1'b0;
                in_xfer = 1'b0;
            end
            if (stop_exp == 0) begin
                expect_true(!hlt && !error, "hlt or error raised too early");
            end
            if ((!nrd || !nwr) && !in_xfer) begin
                in_xfer   = 1'b1;
                xfer_addr = address;
                expect_true(stop_exp == 0, "bus strobe after the core should have stopped");
                if (exp_data) begin
                    xfer_fetch = 1'b0;
                    compare_value("nwr", 32'(nwr), 32'(!exp_write));
                    compare_value("data address", address, exp_addr);
                    if (exp_write) compare_value("data_out", data_out, exp_wdata);
                    exp_data = 1'b0;
                end else begin
                    xfer_fetch = 1'b1;
                    expect_true(nwr, "bus write where a fetch was expected");
                    compare_value("fetch address", address, m_pc);
                    if (last_fetch < 0) begin
                        expect_true(cyc <= 2, "first fetch later than two cycles");
                    end else begin
                        // each cycle of low ready adds one to the four-cycle instruction
                        compare_value("fetch interval", 32'(cyc - last_fetch),
                                      32'(4 + stall_cycles));
                    end
                    last_fetch   = cyc;
                    stall_cycles = 0;
                end
                wait_left    = {$random(seed)} % 4;
                stall_cycles = stall_cycles + wait_left;
            end
            if (in_xfer && !ready) begin
                if (wait_left == 0) begin
                    ready = 1'b1;
                    if (!nwr) begin
                        mem[xfer_addr[11:2]] = data_out;
                    end else begin
                        data_in = mem[xfer_addr[11:2]];
                        if (xfer_fetch && stop_exp == 0) begin
                            model_exec(data_in);
                        end
                    end
                end else begin
                    wait_left--;
                end
            end
            if (stop_exp != 0 && (hlt || error)) begin
                if (quiet == 0) begin
                    compare_value("hlt", 32'(hlt), 32'(stop_exp == 1));
                    compare_value("error", 32'(error), 32'(stop_exp == 2));
                end
                quiet++;
                if (quiet == 8) done = 1'b1;
            end
            if (cyc >= limit && !done) begin
                errors++;
                $display("error: timeout after %0d cycles in run %0d", cyc, kind);
                done = 1'b1;
            end
        end
        ready = 1'b0;
    endtask

    initial begin
        seed    = 19865;
        nreset  = 1'b0;
        ready   = 1'b0;
        data_in = '0;
        errors  = 0;
        checks  = 0;
        run_test(0);
        run_test(1);
        run_test(2);
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 i_tiny32_core.i_tiny32_properties.failures);
        if (errors == 0 && i_tiny32_core.i_tiny32_properties.failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/tiny32_pkg.sv
rtl/stage_sequencer.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/pc_unit.sv
rtl/mem_writeback.sv
rtl/tiny32_core.sv
dv/tiny32_properties.sv
dv/tb_tiny32.sv

//--- Bender.yml
package:
  name: tiny32

sources:
  - rtl/tiny32_pkg.sv
  - rtl/stage_sequencer.sv
  - rtl/instr_decoder.sv
  - rtl/register_file.sv
  - rtl/alu.sv
  - rtl/pc_unit.sv
  - rtl/mem_writeback.sv
  - rtl/tiny32_core.sv
  - target: test
    files:
      - dv/tiny32_properties.sv
      - dv/tb_tiny32.sv
